// File: hw/axi_rd_pkg.sv
// Shared types for the single-beat AXI4 read subsystem
//   axi_resp_e      AXI read response code
//   rd_mst_state_e  read master FSM states
//   rd_slv_state_e  memory slave FSM states

package axi_rd_pkg;

	// **********************************************************************
	// AXI response encoding
	// **********************************************************************
	typedef enum logic [1:0]
	{
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} axi_resp_e;

	// **********************************************************************
	// Read master states
	// **********************************************************************
	// MST_ADDR drives AR valid and R ready, MST_DATA drives R ready only
	typedef enum logic [1:0]
	{
		MST_IDLE = 2'd0,
		MST_ADDR = 2'd1,
		MST_DATA = 2'd2
	} rd_mst_state_e;

	// **********************************************************************
	// Memory slave states
	// **********************************************************************
	typedef enum logic [1:0]
	{
		SLV_IDLE = 2'd0,
		SLV_WAIT = 2'd1,
		SLV_RESP = 2'd2
	} rd_slv_state_e;

endpackage

// File: hw/axi_rd_if.sv
// AXI4 read channel bundle, AR and R only
//   mst modport for the read master
//   slv modport for the memory slave

`timescale 1ns/1ps

interface axi_rd_if
	import axi_rd_pkg::*;
#(
	parameter int ADDR_W = 16,
	parameter int DATA_W = 32
)
();

	// Read address channel
	logic              arvalid;
	logic              arready;
	logic [ADDR_W-1:0] araddr;

	// Read data channel, always a single last beat
	logic              rvalid;
	logic              rready;
	logic [DATA_W-1:0] rdata;
	axi_resp_e         rresp;

	modport mst
	(
		output arvalid,
		output araddr,
		input  arready,
		input  rvalid,
		input  rdata,
		input  rresp,
		output rready
	);

	modport slv
	(
		input  arvalid,
		input  araddr,
		output arready,
		output rvalid,
		output rdata,
		output rresp,
		input  rready
	);

endinterface

// File: hw/rd_cmd_queue.sv
// Read command queue
//   Circular buffer of byte addresses, oldest first
//   Push side fed by the client strobe, pop side by the read master

`timescale 1ns/1ps

module rd_cmd_queue
#(
	parameter int ADDR_W      = 16,
	parameter int QUEUE_DEPTH = 4
)
(
	input  logic              rvx_port_11,
	input  logic              rvx_port_25,
	input  logic              push,
	input  logic [ADDR_W-1:0] push_addr,
	input  logic              pop,
	output logic              full,
	output logic              cmd_valid,
	output logic [ADDR_W-1:0] cmd_addr
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(QUEUE_DEPTH - 1);

	logic [ADDR_W-1:0] slot_mem [QUEUE_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;

	// **********************************************************************
	// Address storage
	// **********************************************************************
	always_ff @(posedge rvx_port_11)
	begin
		if (push)
		begin
			slot_mem[wr_ptr] <= push_addr;
		end
	end

	// **********************************************************************
	// Pointers and occupancy
	// **********************************************************************
	always_ff @(posedge rvx_port_11 or negedge rvx_port_25)
	begin
		if (!rvx_port_25)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
			begin
				wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
			end
			if (pop)
			begin
				rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leaves the count alone
			if (push && !pop)
			begin
				count <= count + 1'b1;
			end
			else if (pop && !push)
			begin
				count <= count - 1'b1;
			end
		end
	end

	assign full      = (count == CNT_W'(QUEUE_DEPTH));
	assign cmd_valid = (count != '0);
	assign cmd_addr  = slot_mem[rd_ptr];

	// Top level gates push with rd_ready and the master pops only on cmd_valid
	assert property (@(posedge rvx_port_11) disable iff (!rvx_port_25)
		!(push && full) && !(pop && !cmd_valid))
		else $error("queue push while full or pop while empty");

endmodule

// File: hw/axi_single_read_master.sv
// Single-beat AXI4 read master
//   Takes one queued address at a time and issues one AR transfer
//   Returns the R beat as a one-cycle response pulse with error flag

`timescale 1ns/1ps

module axi_single_read_master
	import axi_rd_pkg::*;
#(
	parameter int ADDR_W = 16,
	parameter int DATA_W = 32
)
(
	input  logic              rvx_port_11,
	input  logic              rvx_port_25,
	input  logic              cmd_valid,
	input  logic [ADDR_W-1:0] cmd_addr,
	output logic              cmd_pop,
	output logic              rsp_valid,
	output logic [DATA_W-1:0] rsp_data,
	output logic              rsp_err,
	axi_rd_if.mst             axi
);

	rd_mst_state_e     state;
	logic [ADDR_W-1:0] addr_q;
	logic              ar_done;
	logic              r_done;

	// Handshakes on the two channels
	assign ar_done = axi.arvalid & axi.arready;
	assign r_done  = axi.rvalid & axi.rready;

	assign cmd_pop = (state == MST_IDLE) & cmd_valid;

	// **********************************************************************
	// Read FSM
	// **********************************************************************
	always_ff @(posedge rvx_port_11 or negedge rvx_port_25)
	begin
		if (!rvx_port_25)
		begin
			state <= MST_IDLE;
		end
		else
		begin
			unique case (state)
				MST_IDLE:
				begin
					if (cmd_valid)
					begin
						state <= MST_ADDR;
					end
				end
				MST_ADDR:
				begin
					// R may complete on the same edge as AR
					if (ar_done)
					begin
						state <= r_done ? MST_IDLE : MST_DATA;
					end
				end
				MST_DATA:
				begin
					if (r_done)
					begin
						state <= MST_IDLE;
					end
				end
				default:
				begin
					state <= MST_IDLE;
				end
			endcase
		end
	end

	// Address held from pop until the AR handshake
	always_ff @(posedge rvx_port_11)
	begin
		if (cmd_pop)
		begin
			addr_q <= cmd_addr;
		end
	end

	assign axi.arvalid = (state == MST_ADDR);
	assign axi.araddr  = addr_q;
	assign axi.rready  = (state == MST_ADDR) | (state == MST_DATA);

	// Response pulse straight from the R handshake
	assign rsp_valid = r_done;
	assign rsp_data  = axi.rdata;
	assign rsp_err   = (axi.rresp != RESP_OKAY);

	assert property (@(posedge rvx_port_11) disable iff (!rvx_port_25)
		(axi.arvalid && !axi.arready) |=> (axi.arvalid && $stable(axi.araddr)))
		else $error("araddr changed before the AR handshake");

endmodule

// File: hw/axi_rd_mem_slave.sv
// AXI4 read slave over a word memory
//   Load port writes words directly by index
//   Fixed delay from AR handshake to R valid
//   Misaligned or out-of-range addresses answer with SLVERR

`timescale 1ns/1ps

module axi_rd_mem_slave
	import axi_rd_pkg::*;
#(
	parameter int ADDR_W      = 16,
	parameter int DATA_W      = 32,
	parameter int MEM_DEPTH   = 64,
	parameter int MEM_LATENCY = 3
)
(
	input  logic                         rvx_port_11,
	input  logic                         rvx_port_25,
	input  logic                         ld_en,
	input  logic [$clog2(MEM_DEPTH)-1:0] ld_addr,
	input  logic [DATA_W-1:0]            ld_data,
	axi_rd_if.slv                        axi
);

	localparam int IDX_W = $clog2(MEM_DEPTH);
	localparam int OFF_W = $clog2(DATA_W / 8);
	localparam int LAT_W = $clog2(MEM_LATENCY + 1);
	// Byte offset bits inside one word
	localparam logic [ADDR_W-1:0] OFF_MASK = ADDR_W'((DATA_W / 8) - 1);

	logic [DATA_W-1:0] mem [MEM_DEPTH];

	rd_slv_state_e     state;
	logic [LAT_W-1:0]  wait_cnt;
	logic [ADDR_W-1:0] addr_q;
	logic [ADDR_W-1:0] dec_addr;
	logic [ADDR_W-1:0] word_idx;
	logic              addr_bad;
	logic              ar_done;
	logic              r_done;
	logic              to_resp;
	logic [DATA_W-1:0] rdata_q;
	axi_resp_e         rresp_q;

	// **********************************************************************
	// Word memory and load port
	// **********************************************************************
	always_ff @(posedge rvx_port_11)
	begin
		if (ld_en)
		begin
			mem[ld_addr] <= ld_data;
		end
	end

	// Address decode, live AR address while idle, captured one afterwards
	assign dec_addr = (state == SLV_IDLE) ? axi.araddr : addr_q;
	assign word_idx = dec_addr >> OFF_W;
	assign addr_bad = ((dec_addr & OFF_MASK) != '0) || (word_idx >= ADDR_W'(MEM_DEPTH));

	assign ar_done = axi.arvalid & axi.arready;
	assign r_done  = axi.rvalid & axi.rready;

	// Entering SLV_RESP on this edge, straight from the handshake for a latency of one
	assign to_resp = (MEM_LATENCY == 1) ? ar_done :
		((state == SLV_WAIT) && (wait_cnt == LAT_W'(1)));

	// **********************************************************************
	// Slave FSM
	// **********************************************************************
	always_ff @(posedge rvx_port_11 or negedge rvx_port_25)
	begin
		if (!rvx_port_25)
		begin
			state    <= SLV_IDLE;
			wait_cnt <= '0;
		end
		else
		begin
			unique case (state)
				SLV_IDLE:
				begin
					if (ar_done)
					begin
						wait_cnt <= LAT_W'(MEM_LATENCY - 1);
						state    <= to_resp ? SLV_RESP : SLV_WAIT;
					end
				end
				SLV_WAIT:
				begin
					if (to_resp)
					begin
						state <= SLV_RESP;
					end
					else
					begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				SLV_RESP:
				begin
					if (r_done)
					begin
						state <= SLV_IDLE;
					end
				end
				default:
				begin
					state <= SLV_IDLE;
				end
			endcase
		end
	end

	// Address and response payload
	always_ff @(posedge rvx_port_11)
	begin
		if (ar_done)
		begin
			addr_q <= axi.araddr;
		end
		if (to_resp)
		begin
			rdata_q <= addr_bad ? '0 : mem[word_idx[IDX_W-1:0]];
			rresp_q <= addr_bad ? RESP_SLVERR : RESP_OKAY;
		end
	end

	assign axi.arready = (state == SLV_IDLE);
	assign axi.rvalid  = (state == SLV_RESP);
	assign axi.rdata   = rdata_q;
	assign axi.rresp   = rresp_q;

	assert property (@(posedge rvx_port_11) disable iff (!rvx_port_25)
		(axi.rvalid && !axi.rready) |=> (axi.rvalid && $stable(axi.rdata)))
		else $error("R beat dropped or changed before rready");

endmodule

// File: hw/axi_read_subsys_top.sv
// Single-beat AXI4 read subsystem top level
//   rd_cmd_queue           holds client read addresses in order
//   axi_single_read_master one read in flight, MST_IDLE/ADDR/DATA
//   axi_rd_mem_slave       word memory answering the AR/R channels

`timescale 1ns/1ps

module axi_read_subsys_top
#(
	parameter int ADDR_W      = 16,
	parameter int DATA_W      = 32,
	parameter int QUEUE_DEPTH = 4,
	parameter int MEM_DEPTH   = 64,
	parameter int MEM_LATENCY = 3
)
(
	input  logic                         rvx_port_11,
	input  logic                         rvx_port_25,
	input  logic                         rd_req,
	input  logic [ADDR_W-1:0]            rd_addr,
	input  logic                         ld_en,
	input  logic [$clog2(MEM_DEPTH)-1:0] ld_addr,
	input  logic [DATA_W-1:0]            ld_data,
	output logic                         rd_ready,
	output logic                         rsp_valid,
	output logic [DATA_W-1:0]            rsp_data,
	output logic                         rsp_err
);

	logic              q_full;
	logic              q_push;
	logic              cmd_valid;
	logic              cmd_pop;
	logic [ADDR_W-1:0] cmd_addr;

	axi_rd_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) axi_bus ();

	// Client strobe counts only while the queue has room
	assign rd_ready = ~q_full;
	assign q_push   = rd_req & rd_ready;

	rd_cmd_queue #(
		.ADDR_W      (ADDR_W),
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) rd_cmd_queue_inst (
		.rvx_port_11 (rvx_port_11),
		.rvx_port_25 (rvx_port_25),
		.push        (q_push),
		.push_addr   (rd_addr),
		.pop         (cmd_pop),
		.full        (q_full),
		.cmd_valid   (cmd_valid),
		.cmd_addr    (cmd_addr)
	);

	// Master leaves MST_IDLE by popping the queue head
	axi_single_read_master #(
		.ADDR_W (ADDR_W),
		.DATA_W (DATA_W)
	) axi_single_read_master_inst (
		.rvx_port_11 (rvx_port_11),
		.rvx_port_25 (rvx_port_25),
		.cmd_valid   (cmd_valid),
		.cmd_addr    (cmd_addr),
		.cmd_pop     (cmd_pop),
		.rsp_valid   (rsp_valid),
		.rsp_data    (rsp_data),
		.rsp_err     (rsp_err),
		.axi         (axi_bus.mst)
	);

	axi_rd_mem_slave #(
		.ADDR_W      (ADDR_W),
		.DATA_W      (DATA_W),
		.MEM_DEPTH   (MEM_DEPTH),
		.MEM_LATENCY (MEM_LATENCY)
	) axi_rd_mem_slave_inst (
		.rvx_port_11 (rvx_port_11),
		.rvx_port_25 (rvx_port_25),
		.ld_en       (ld_en),
		.ld_addr     (ld_addr),
		.ld_data     (ld_data),
		.axi         (axi_bus.slv)
	);

endmodule

// File: sim/axi_read_subsys_tb.sv
// Testbench for the single-beat AXI4 read subsystem
//   Stimulus table of loads, single reads and read bursts
//   Fibonacci LFSR for random load data and gaps
//   Reference memory model and expected-response queue
//   Response monitor, value checker and watchdog

`timescale 1ns/1ps

module axi_read_subsys_tb;

	localparam int ADDR_W       = 16;
	localparam int DATA_W       = 32;
	localparam int QUEUE_DEPTH  = 4;
	localparam int MEM_DEPTH    = 64;
	localparam int MEM_LATENCY  = 3;
	localparam int IDX_W        = $clog2(MEM_DEPTH);
	localparam int OFF_W        = $clog2(DATA_W / 8);
	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_ROWS     = 18;
	localparam int DRAIN_CYCLES = (QUEUE_DEPTH + 2) * (MEM_LATENCY + 4) + 10;
	localparam int WATCHDOG_CYCLES =
		NUM_ROWS * (QUEUE_DEPTH + 1) * (MEM_LATENCY + 4) + 2 * MEM_DEPTH + 200;
	localparam logic [15:0] LFSR_SEED = 16'd43531;

	// Row operations
	localparam logic [1:0] OP_LOAD  = 2'd0;
	localparam logic [1:0] OP_READ  = 2'd1;
	localparam logic [1:0] OP_BURST = 2'd2;
	localparam logic [7:0] GAP_RND  = 8'hFF;

	typedef struct packed
	{
		logic [1:0]        op;
		logic              rnd_data;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic [7:0]        gap;
	} row_t;

	logic              rvx_port_11;
	logic              rvx_port_25;
	logic              rd_req;
	logic [ADDR_W-1:0] rd_addr;
	logic              ld_en;
	logic [IDX_W-1:0]  ld_addr;
	logic [DATA_W-1:0] ld_data;
	logic              rd_ready;
	logic              rsp_valid;
	logic [DATA_W-1:0] rsp_data;
	logic              rsp_err;

	row_t              stim_tab [NUM_ROWS];
	logic [DATA_W-1:0] ref_mem [MEM_DEPTH];
	logic [DATA_W-1:0] exp_data [$];
	logic              exp_err [$];
	logic [15:0]       lfsr_state;
	logic              saw_full;

	axi_read_subsys_top axi_read_subsys_top_inst
	(
		.rvx_port_11 (rvx_port_11),
		.rvx_port_25 (rvx_port_25),
		.rd_req      (rd_req),
		.rd_addr     (rd_addr),
		.ld_en       (ld_en),
		.ld_addr     (ld_addr),
		.ld_data     (ld_data),
		.rd_ready    (rd_ready),
		.rsp_valid   (rsp_valid),
		.rsp_data    (rsp_data),
		.rsp_err     (rsp_err)
	);

	initial
	begin
		rvx_port_11 = 1'b0;
		forever #(CLK_PERIOD / 2) rvx_port_11 = ~rvx_port_11;
	end

	// **********************************************************************
	// Helpers
	// **********************************************************************
	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [DATA_W-1:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[DATA_W-2:0], lfsr_state[0]};
		end
	endtask

	// Slave rule: misaligned or past the last word gives an error
	function automatic logic addr_is_bad(input logic [ADDR_W-1:0] a);
		return (a[OFF_W-1:0] != '0) || ((a >> OFF_W) >= ADDR_W'(MEM_DEPTH));
	endfunction

	function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] a);
		if (addr_is_bad(a))
		begin
			return '0;
		end
		return ref_mem[a[OFF_W +: IDX_W]];
	endfunction

	task automatic check_value(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			$display("Finished with errors");
			$fatal(1, "value check failed");
		end
	endtask

	// Bounded wait for every accepted read to come back
	task automatic wait_drain();
		for (int k = 0; k < DRAIN_CYCLES && exp_data.size() != 0; k++)
		begin
			@(posedge rvx_port_11);
		end
	endtask

	task automatic fill_table();
		stim_tab[0]  = '{OP_LOAD,  1'b0, 16'h0003, 32'h1234_5678, 8'd1};
		stim_tab[1]  = '{OP_LOAD,  1'b1, 16'h000A, 32'h0,         GAP_RND};
		stim_tab[2]  = '{OP_LOAD,  1'b0, 16'h003F, 32'hDEAD_BEEF, 8'd0};
		stim_tab[3]  = '{OP_READ,  1'b0, 16'h000C, 32'h0,         8'd2};
		stim_tab[4]  = '{OP_READ,  1'b0, 16'h0028, 32'h0,         GAP_RND};
		stim_tab[5]  = '{OP_READ,  1'b0, 16'h00FC, 32'h0,         8'd0};
		stim_tab[6]  = '{OP_READ,  1'b0, 16'h0000, 32'h0,         8'd1};
		// Word index at and far past the memory end
		stim_tab[7]  = '{OP_READ,  1'b0, 16'h0100, 32'h0,         8'd1};
		stim_tab[8]  = '{OP_READ,  1'b0, 16'hFFF0, 32'h0,         8'd0};
		// Misaligned byte addresses
		stim_tab[9]  = '{OP_READ,  1'b0, 16'h0012, 32'h0,         8'd1};
		stim_tab[10] = '{OP_READ,  1'b0, 16'h0021, 32'h0,         GAP_RND};
		stim_tab[11] = '{OP_BURST, 1'b0, 16'h0040, 32'h0,         8'd2};
		stim_tab[12] = '{OP_BURST, 1'b0, 16'h00F8, 32'h0,         GAP_RND};
		// Rewrite between two reads of word 5
		stim_tab[13] = '{OP_READ,  1'b0, 16'h0014, 32'h0,         8'd0};
		stim_tab[14] = '{OP_LOAD,  1'b0, 16'h0005, 32'hCAFE_F00D, 8'd0};
		stim_tab[15] = '{OP_READ,  1'b0, 16'h0014, 32'h0,         8'd1};
		stim_tab[16] = '{OP_LOAD,  1'b1, 16'h0005, 32'h0,         8'd0};
		stim_tab[17] = '{OP_READ,  1'b0, 16'h0014, 32'h0,         GAP_RND};
	endtask

	// **********************************************************************
	// Monitor, sampled mid-cycle where DUT outputs are stable
	// **********************************************************************
	always @(negedge rvx_port_11)
	begin
		if (rvx_port_25)
		begin
			// Request taken on the coming rising edge
			if (rd_req && rd_ready)
			begin
				exp_data.push_back(expected_word(rd_addr));
				exp_err.push_back(addr_is_bad(rd_addr));
			end
			if (!rd_ready)
			begin
				saw_full = 1'b1;
			end
			if (rsp_valid)
			begin
				if (exp_data.size() == 0)
				begin
					$display("response arrived with no read outstanding");
					$display("Finished with errors");
					$fatal(1, "unexpected response");
				end
				check_value("rsp_data", rsp_data, exp_data.pop_front());
				check_value("rsp_err", {31'b0, rsp_err}, {31'b0, exp_err.pop_front()});
			end
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles without finishing", WATCHDOG_CYCLES);
		$display("Finished with errors");
		$fatal(1, "timeout");
	end

	// **********************************************************************
	// Main sequence
	// **********************************************************************
	initial
	begin
		row_t              row;
		logic [DATA_W-1:0] rnd;
		int                gap;

		rvx_port_25 = 1'b0;
		rd_req      = 1'b0;
		rd_addr     = '0;
		ld_en       = 1'b0;
		ld_addr     = '0;
		ld_data     = '0;
		saw_full    = 1'b0;
		lfsr_state  = LFSR_SEED;
		fill_table();

		repeat (RESET_CYCLES) @(posedge rvx_port_11);
		rvx_port_25 <= 1'b1;

		// Idle state right after reset
		@(negedge rvx_port_11);
		check_value("rsp_valid", {31'b0, rsp_valid}, 32'h0);
		check_value("rd_ready", {31'b0, rd_ready}, 32'h1);

		// Every word gets a value derived from its full index
		for (int i = 0; i < MEM_DEPTH; i++)
		begin
			@(posedge rvx_port_11);
			ld_en   <= 1'b1;
			ld_addr <= IDX_W'(i);
			ld_data <= {8'hC3, 8'(i), ~8'(i), 8'(i * 7)};
			ref_mem[i] = {8'hC3, 8'(i), ~8'(i), 8'(i * 7)};
		end
		@(posedge rvx_port_11);
		ld_en <= 1'b0;

		for (int r = 0; r < NUM_ROWS; r++)
		begin
			row = stim_tab[r];
			case (row.op)
				OP_LOAD:
				begin
					rnd = row.data;
					if (row.rnd_data)
					begin
						take_bits(DATA_W, rnd);
					end
					@(posedge rvx_port_11);
					ld_en   <= 1'b1;
					ld_addr <= row.addr[IDX_W-1:0];
					ld_data <= rnd;
					ref_mem[row.addr[IDX_W-1:0]] = rnd;
					@(posedge rvx_port_11);
					ld_en <= 1'b0;
				end
				OP_READ:
				begin
					@(posedge rvx_port_11);
					rd_req  <= 1'b1;
					rd_addr <= row.addr;
					@(negedge rvx_port_11);
					while (!rd_ready)
					begin
						@(negedge rvx_port_11);
					end
					@(posedge rvx_port_11);
					rd_req <= 1'b0;
					wait_drain();
				end
				default:
				begin
					// Back-to-back strobes, some dropped once the queue fills
					@(posedge rvx_port_11);
					saw_full = 1'b0;
					for (int i = 0; i < QUEUE_DEPTH + 2; i++)
					begin
						rd_req  <= 1'b1;
						rd_addr <= row.addr + ADDR_W'(4 * i);
						@(posedge rvx_port_11);
					end
					rd_req <= 1'b0;
					wait_drain();
					check_value("rd_ready low during burst", {31'b0, saw_full}, 32'h1);
				end
			endcase
			gap = int'(row.gap);
			if (row.gap == GAP_RND)
			begin
				take_bits(3, rnd);
				gap = int'(rnd[2:0]);
			end
			repeat (gap) @(posedge rvx_port_11);
		end

		wait_drain();
		if (exp_data.size() != 0)
		begin
			$display("responses missing, %0d reads never answered", exp_data.size());
			$display("Finished with errors");
			$fatal(1, "missing responses");
		end
		else
		begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

// File: build.f
hw/axi_rd_pkg.sv
hw/axi_rd_if.sv
hw/rd_cmd_queue.sv
hw/axi_single_read_master.sv
hw/axi_rd_mem_slave.sv
hw/axi_read_subsys_top.sv
sim/axi_read_subsys_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile the read subsystem testbench with Verilator and run it.
# The exit status is the simulator's own, so a failing run returns non-zero.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
	--top-module axi_read_subsys_tb \
	-f build.f \
	-o sim_axi_read &&
./obj_dir/sim_axi_read ||
exit 1
